//--- dv/iqx_model.sv
`include "iqx_consts.svh"

module iqx_model;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ENTRIES = `IQX_THREADS * `IQX_DEPTH;

  int                     wr_ptr    [`IQX_THREADS];
  int                     rd_ptr    [`IQX_THREADS];
  int                     cnt       [`IQX_THREADS];
  logic [`IQX_DATA_W-1:0] mem       [ENTRIES];
  bit                     written   [ENTRIES];  // Entry has taken at least one push
  int                     head_addr [2];        // Registered read addresses

  // Thread picks the region, pointer wraps inside it
  function automatic int addr_of(input int thread, input int ptr);
    return thread * `IQX_DEPTH + (ptr % `IQX_DEPTH);
  endfunction

  function automatic bit full_of(input int thread);
    return cnt[thread] >= `IQX_FULL_LEVEL;
  endfunction

  function automatic int count_of(input int thread);
    return cnt[thread];
  endfunction

  function automatic logic [`IQX_DATA_W-1:0] data_at(input int port);
    return mem[head_addr[port]];
  endfunction

  function automatic bit known(input int port);
    return written[head_addr[port]];
  endfunction

  task automatic clear_state();
    for (int t = 0; t < `IQX_THREADS; t++) begin
      wr_ptr[t] = 0;
      rd_ptr[t] = 0;
      cnt[t]    = 0;
    end
    for (int a = 0; a < ENTRIES; a++) begin
      written[a] = 1'b0;
    end
    head_addr[0] = 0;
    head_addr[1] = 1;
  endtask

  // One clock edge with reset low
  task automatic apply_edge(
    input bit                     except,
    input int                     except_thread,
    input bit                     fstall,
    input bit                     write_wen,
    input int                     write_thread,
    input int                     write_cnt,
    input logic [`IQX_DATA_W-1:0] d0,
    input logic [`IQX_DATA_W-1:0] d1,
    input logic [`IQX_DATA_W-1:0] d2,
    input logic [`IQX_DATA_W-1:0] d3,
    input bit                     stall,
    input int                     read_thread,
    input int                     read_cnt
  );
    logic [`IQX_DATA_W-1:0] lane [`IQX_WR_LANES];
    bit                     accept;
    int                     a;
    lane[0] = d0;
    lane[1] = d1;
    lane[2] = d2;
    lane[3] = d3;
    accept = write_wen && !fstall && !full_of(write_thread);  // Count before the edge
    if (accept) begin
      for (int k = 0; k < write_cnt; k++) begin
        a          = addr_of(write_thread, wr_ptr[write_thread] + k);
        mem[a]     = lane[k];
        written[a] = 1'b1;
      end
      wr_ptr[write_thread] = (wr_ptr[write_thread] + write_cnt) % `IQX_DEPTH;
      cnt[write_thread]    = cnt[write_thread] + write_cnt;
    end
    if (!stall) begin
      rd_ptr[read_thread] = (rd_ptr[read_thread] + read_cnt) % `IQX_DEPTH;
      cnt[read_thread]    = cnt[read_thread] - read_cnt;
    end
    if (except) begin  // Memory keeps its contents
      wr_ptr[except_thread] = 0;
      rd_ptr[except_thread] = 0;
      cnt[except_thread]    = 0;
    end
    if (!stall) begin
      head_addr[0] = addr_of(read_thread, rd_ptr[read_thread]);
      head_addr[1] = addr_of(read_thread, rd_ptr[read_thread] + 1);
    end
  endtask

endmodule

//--- dv/iqx_tb.sv
`include "iqx_consts.svh"

module iqx_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import iqx_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 3;
  localparam int NUM_CYCLES  = 2000;
  localparam int PHASE_LEN   = 250;  // Cycles per fill or drain phase
  localparam int WATCHDOG_NS = (RST_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   except;
  logic                   except_thread;
  logic                   fstall;
  logic                   full_stall;
  logic                   write_wen;
  logic                   write_thread;
  logic [`IQX_WCNT_W-1:0] write_cnt;
  iqx_entry_t             write_data0;
  iqx_entry_t             write_data1;
  iqx_entry_t             write_data2;
  iqx_entry_t             write_data3;
  logic                   stall;
  logic                   read_thread;
  logic [`IQX_RCNT_W-1:0] read_cnt;
  iqx_entry_t             read_data0;
  iqx_entry_t             read_data1;

  integer seed       = 23003;
  int     checks     = 0;
  int     mismatches = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  iqx_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .except        (except),
    .except_thread (except_thread),
    .fstall        (fstall),
    .full_stall    (full_stall),
    .write_wen     (write_wen),
    .write_thread  (write_thread),
    .write_cnt     (write_cnt),
    .write_data0   (write_data0),
    .write_data1   (write_data1),
    .write_data2   (write_data2),
    .write_data3   (write_data3),
    .stall         (stall),
    .read_thread   (read_thread),
    .read_cnt      (read_cnt),
    .read_data0    (read_data0),
    .read_data1    (read_data1)
  );

  iqx_model u_model ();

  function automatic int unsigned pick_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  function automatic iqx_entry_t rand_word();
    return iqx_entry_t'({$random(seed)});
  endfunction

  // Fill phases push hard and pop rarely while drain phases do the reverse
  task automatic drive_next(input int cyc);
    bit          fill_phase;
    int          rt;
    int          avail;
    int unsigned wc;
    int unsigned rc;
    fill_phase = ((cyc / PHASE_LEN) % 2) == 0;
    rt         = pick_below(2);
    avail      = u_model.count_of(rt);
    if (avail > `IQX_RD_LANES)
      avail = `IQX_RD_LANES;
    wc = pick_below(`IQX_WR_LANES + 1);
    rc = pick_below(avail + 1);  // Never pop more than present
    except        <= (pick_below(40) == 0);
    except_thread <= (pick_below(2) == 1);
    fstall        <= (pick_below(8) == 0);
    write_wen     <= fill_phase ? (pick_below(10) < 8) : (pick_below(10) < 3);
    write_thread  <= (pick_below(2) == 1);
    write_cnt     <= wc[`IQX_WCNT_W-1:0];
    write_data0   <= rand_word();
    write_data1   <= rand_word();
    write_data2   <= rand_word();
    write_data3   <= rand_word();
    stall         <= fill_phase ? (pick_below(10) < 6) : (pick_below(10) < 2);
    read_thread   <= rt[0];
    read_cnt      <= rc[`IQX_RCNT_W-1:0];
  endtask

  task automatic check_outputs();
    logic       exp_full;
    iqx_entry_t exp_data;
    iqx_cnt_t   exp_cnt;
    exp_full = u_model.full_of(write_thread);
    checks++;
    assert (full_stall === exp_full) else begin
      mismatches++;
      $display("Mismatch: full_stall expected 0x%h got 0x%h, write_thread %0d",
               exp_full, full_stall, write_thread);
    end
    // Entries never written hold X in the DUT memory
    if (u_model.known(0)) begin
      exp_data = u_model.data_at(0);
      checks++;
      assert (read_data0 === exp_data) else begin
        mismatches++;
        $display("Mismatch: read_data0 expected 0x%h got 0x%h", exp_data, read_data0);
      end
    end
    if (u_model.known(1)) begin
      exp_data = u_model.data_at(1);
      checks++;
      assert (read_data1 === exp_data) else begin
        mismatches++;
        $display("Mismatch: read_data1 expected 0x%h got 0x%h", exp_data, read_data1);
      end
    end
    for (int t = 0; t < `IQX_THREADS; t++) begin
      exp_cnt = iqx_cnt_t'(u_model.count_of(t));
      checks++;
      assert (u_dut.u_ctrl.cnt[t] === exp_cnt) else begin
        mismatches++;
        $display("Mismatch: cnt[%0d] expected 0x%h got 0x%h",
                 t, exp_cnt, u_dut.u_ctrl.cnt[t]);
      end
    end
  endtask

  initial begin
    rst           = 1'b1;
    except        = 1'b0;
    except_thread = 1'b0;
    fstall        = 1'b0;
    write_wen     = 1'b0;
    write_thread  = 1'b0;
    write_cnt     = '0;
    write_data0   = '0;
    write_data1   = '0;
    write_data2   = '0;
    write_data3   = '0;
    stall         = 1'b1;
    read_thread   = 1'b0;
    read_cnt      = '0;
    u_model.clear_state();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clk);
      check_outputs();
      @(posedge clk);
      // Inputs still hold the values the DUT sampled at this edge
      u_model.apply_edge(except, except_thread, fstall, write_wen, write_thread,
                         write_cnt, write_data0, write_data1, write_data2,
                         write_data3, stall, read_thread, read_cnt);
      drive_next(cyc);
    end
    @(negedge clk);
    check_outputs();
    $display("Checks run: %0d, mismatches: %0d", checks, mismatches);
    if (mismatches == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

endmodule

//--- list.f
+incdir+rtl
rtl/iqx_pkg.sv
rtl/iqx_wr_if.sv
rtl/iqx_ctrl.sv
rtl/iqx_write_align.sv
rtl/iqx_ram.sv
rtl/iqx_top.sv
dv/iqx_model.sv
dv/iqx_tb.sv

//--- rtl/iqx_consts.svh
`ifndef IQX_CONSTS_SVH
`define IQX_CONSTS_SVH

`define IQX_THREADS    2   // Hardware threads sharing the memory
`define IQX_DEPTH      16  // Entries per thread region
`define IQX_WR_LANES   4   // Max pushes per cycle
`define IQX_RD_LANES   2   // Max pops per cycle
`define IQX_FULL_LEVEL 13  // Occupancy that raises full_stall
`define IQX_DATA_W     24  // Payload width

// Widths of the push and pop length fields
`define IQX_WCNT_W $clog2(`IQX_WR_LANES + 1)
`define IQX_RCNT_W $clog2(`IQX_RD_LANES + 1)

`endif

//--- rtl/iqx_ctrl.sv
`include "iqx_consts.svh"

module iqx_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    except,
  input  logic                    except_thread,
  input  logic                    fstall,
  input  logic                    write_wen,
  input  logic                    write_thread,
  input  logic [`IQX_WCNT_W-1:0]  write_cnt,
  input  logic                    stall,
  input  logic                    read_thread,
  input  logic [`IQX_RCNT_W-1:0]  read_cnt,
  output logic                    full_stall,
  output logic                    push_en,
  output iqx_pkg::iqx_addr_t      wr_base,
  output iqx_pkg::iqx_addr_t      rd_addr0,
  output iqx_pkg::iqx_addr_t      rd_addr1
);
  import iqx_pkg::*;

  iqx_ptr_t wr_ptr     [`IQX_THREADS];
  iqx_ptr_t rd_ptr     [`IQX_THREADS];
  iqx_cnt_t cnt        [`IQX_THREADS];
  iqx_ptr_t wr_ptr_nxt [`IQX_THREADS];
  iqx_ptr_t rd_ptr_nxt [`IQX_THREADS];
  iqx_cnt_t cnt_nxt    [`IQX_THREADS];

  logic [`IQX_THREADS-1:0] push_hit;
  logic [`IQX_THREADS-1:0] pop_hit;
  logic [`IQX_THREADS-1:0] flush_hit;

  // Threshold leaves room for one full 4-wide push
  assign full_stall = cnt[write_thread] >= `IQX_FULL_LEVEL;

  // Dropped pushes are not held, the decoder replays them
  assign push_en = write_wen && !fstall && !full_stall;

  assign wr_base = '{thread: write_thread, ptr: wr_ptr[write_thread]};

  always_comb begin
    for (int t = 0; t < `IQX_THREADS; t++) begin
      push_hit[t]  = push_en && (write_thread == t);
      pop_hit[t]   = !stall && (read_thread == t);
      flush_hit[t] = except && (except_thread == t);

      wr_ptr_nxt[t] = wr_ptr[t];
      rd_ptr_nxt[t] = rd_ptr[t];
      cnt_nxt[t]    = cnt[t];

      if (push_hit[t]) begin
        wr_ptr_nxt[t] = wr_ptr[t] + iqx_ptr_t'(write_cnt);  // Wraps inside region
        cnt_nxt[t]    = cnt_nxt[t] + iqx_cnt_t'(write_cnt);
      end

      if (pop_hit[t]) begin
        rd_ptr_nxt[t] = rd_ptr[t] + iqx_ptr_t'(read_cnt);
        cnt_nxt[t]    = cnt_nxt[t] - iqx_cnt_t'(read_cnt);
      end

      // Flush wins over push and pop of the same thread
      if (flush_hit[t]) begin
        wr_ptr_nxt[t] = '0;
        rd_ptr_nxt[t] = '0;
        cnt_nxt[t]    = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '{default: '0};
      rd_ptr   <= '{default: '0};
      cnt      <= '{default: '0};
      rd_addr0 <= '{thread: 1'b0, ptr: iqx_ptr_t'(0)};
      rd_addr1 <= '{thread: 1'b0, ptr: iqx_ptr_t'(1)};
    end else begin
      wr_ptr <= wr_ptr_nxt;
      rd_ptr <= rd_ptr_nxt;
      cnt    <= cnt_nxt;
      if (!stall) begin  // Load the new head and the entry after it
        rd_addr0 <= '{thread: read_thread, ptr: rd_ptr_nxt[read_thread]};
        rd_addr1 <= '{thread: read_thread,
                      ptr: rd_ptr_nxt[read_thread] + iqx_ptr_t'(1)};
      end
    end
  end

  // The issue stage may only take entries that are present
  a_pop_within_count: assert property (
    @(posedge clk) disable iff (rst)
    !stall |-> (iqx_cnt_t'(read_cnt) <= cnt[read_thread])
  ) else $error("iqx_ctrl: pop of %0d from thread %0d holding %0d",
                read_cnt, read_thread, cnt[read_thread]);

  // Full threshold plus lane count must keep each region from overflowing
  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    (cnt[0] <= `IQX_DEPTH) && (cnt[1] <= `IQX_DEPTH)
  ) else $error("iqx_ctrl: occupancy above depth, %0d %0d", cnt[0], cnt[1]);

endmodule

//--- rtl/iqx_pkg.sv
`include "iqx_consts.svh"

package iqx_pkg;

  // One side-data payload word
  typedef logic [`IQX_DATA_W-1:0] iqx_entry_t;

  // Position inside one thread region
  typedef logic [$clog2(`IQX_DEPTH)-1:0] iqx_ptr_t;

  // Occupancy of one thread, 0 to IQX_DEPTH inclusive
  typedef logic [$clog2(`IQX_DEPTH):0] iqx_cnt_t;

  // Memory address, thread selects the region
  typedef struct packed {
    logic     thread;
    iqx_ptr_t ptr;
  } iqx_addr_t;

endpackage

//--- rtl/iqx_ram.sv
`include "iqx_consts.svh"

module iqx_ram #(
  parameter type entry_t = iqx_pkg::iqx_entry_t
) (
  input  logic               clk,
  iqx_wr_if.dst              wr,
  input  iqx_pkg::iqx_addr_t rd_addr0,
  input  iqx_pkg::iqx_addr_t rd_addr1,
  output entry_t             rd_data0,
  output entry_t             rd_data1
);
  import iqx_pkg::*;

  localparam int ENTRIES = `IQX_THREADS * `IQX_DEPTH;

  entry_t mem [ENTRIES];

  always_ff @(posedge clk) begin
    for (int k = 0; k < `IQX_WR_LANES; k++) begin
      if (wr.wen[k]) begin
        mem[wr.addr[k]] <= wr.data[k];
      end
    end
  end

  // Addresses come in registered, so a write shows on the same-cycle read
  assign rd_data0 = mem[rd_addr0];
  assign rd_data1 = mem[rd_addr1];

  // Aligner wrap must keep the live lanes apart
  for (genvar i = 0; i < `IQX_WR_LANES; i++) begin : g_lane_a
    for (genvar j = i + 1; j < `IQX_WR_LANES; j++) begin : g_lane_b
      a_lane_addr_unique: assert property (
        @(posedge clk)
        (wr.wen[i] && wr.wen[j]) |-> (wr.addr[i] != wr.addr[j])
      ) else $error("iqx_ram: lanes %0d and %0d both write entry 0x%0h",
                    i, j, wr.addr[i]);
    end
  end

endmodule

//--- rtl/iqx_top.sv
`include "iqx_consts.svh"

module iqx_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   except,
  input  logic                   except_thread,
  input  logic                   fstall,
  output logic                   full_stall,
  input  logic                   write_wen,
  input  logic                   write_thread,
  input  logic [`IQX_WCNT_W-1:0] write_cnt,
  input  iqx_pkg::iqx_entry_t    write_data0,
  input  iqx_pkg::iqx_entry_t    write_data1,
  input  iqx_pkg::iqx_entry_t    write_data2,
  input  iqx_pkg::iqx_entry_t    write_data3,
  input  logic                   stall,
  input  logic                   read_thread,
  input  logic [`IQX_RCNT_W-1:0] read_cnt,
  output iqx_pkg::iqx_entry_t    read_data0,
  output iqx_pkg::iqx_entry_t    read_data1
);
  import iqx_pkg::*;

  logic      push_en;
  iqx_addr_t wr_base;
  iqx_addr_t rd_addr0;
  iqx_addr_t rd_addr1;

  iqx_wr_if #(.entry_t(iqx_entry_t)) u_wr_if ();  // Aligner to memory lanes

  iqx_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .except        (except),
    .except_thread (except_thread),
    .fstall        (fstall),
    .write_wen     (write_wen),
    .write_thread  (write_thread),
    .write_cnt     (write_cnt),
    .stall         (stall),
    .read_thread   (read_thread),
    .read_cnt      (read_cnt),
    .full_stall    (full_stall),
    .push_en       (push_en),
    .wr_base       (wr_base),
    .rd_addr0      (rd_addr0),
    .rd_addr1      (rd_addr1)
  );

  iqx_write_align #(.entry_t(iqx_entry_t)) u_align (
    .push_en   (push_en),
    .wr_base   (wr_base),
    .write_cnt (write_cnt),
    .data0     (write_data0),
    .data1     (write_data1),
    .data2     (write_data2),
    .data3     (write_data3),
    .wr        (u_wr_if.src)
  );

  iqx_ram #(.entry_t(iqx_entry_t)) u_ram (
    .clk      (clk),
    .wr       (u_wr_if.dst),
    .rd_addr0 (rd_addr0),
    .rd_addr1 (rd_addr1),
    .rd_data0 (read_data0),
    .rd_data1 (read_data1)
  );

endmodule

//--- rtl/iqx_wr_if.sv
`include "iqx_consts.svh"

interface iqx_wr_if #(
  parameter type entry_t = iqx_pkg::iqx_entry_t
);
  import iqx_pkg::*;

  iqx_addr_t                addr [`IQX_WR_LANES];  // Per-lane target entry
  logic [`IQX_WR_LANES-1:0] wen;                   // Per-lane write strobe
  entry_t                   data [`IQX_WR_LANES];  // Per-lane payload

  modport src (
    output addr,
    output wen,
    output data
  );

  modport dst (
    input addr,
    input wen,
    input data
  );

endinterface

//--- rtl/iqx_write_align.sv
`include "iqx_consts.svh"

module iqx_write_align #(
  parameter type entry_t = iqx_pkg::iqx_entry_t
) (
  input  logic                   push_en,
  input  iqx_pkg::iqx_addr_t     wr_base,
  input  logic [`IQX_WCNT_W-1:0] write_cnt,
  input  entry_t                 data0,
  input  entry_t                 data1,
  input  entry_t                 data2,
  input  entry_t                 data3,
  iqx_wr_if.src                  wr
);
  import iqx_pkg::*;

  entry_t lane_data [`IQX_WR_LANES];

  // Decoder already packs entries from lane 0 upward
  assign lane_data = '{data0, data1, data2, data3};

  always_comb begin
    for (int k = 0; k < `IQX_WR_LANES; k++) begin
      // Thermometer enable, lane k live when more than k entries pushed
      wr.wen[k]  = push_en && (write_cnt > k);
      wr.addr[k] = '{thread: wr_base.thread,
                     ptr: wr_base.ptr + iqx_ptr_t'(k)};  // Stays in thread region
      wr.data[k] = lane_data[k];
    end
  end

endmodule
